// ==== design/bridge_ifs.sv ====
// ====================
// Internal interfaces of the disk bridge
// ctrl_evt_if  controller events and buffer port
// mount_iface  latched image mount state
// ====================

`timescale 1ns/1ns

interface ctrl_evt_if import disk_pkg::*; #(
	parameter int BUF_AW = BUF_AW_DEF
) ();

	// Block request pulses and target drive
	logic             blk_rd_req;
	logic             blk_wr_req;
	logic [DRV_W-1:0] drv_num;

	// Controller side of the sector buffer
	logic              buf_wr;
	logic [7:0]        buf_wdata;
	logic [7:0]        buf_rdata;
	logic [BUF_AW-1:0] buf_ptr;

	modport src (
		output blk_rd_req, blk_wr_req, drv_num,
		output buf_wr, buf_wdata, buf_ptr,
		input  buf_rdata
	);

	modport req (input blk_rd_req, blk_wr_req, drv_num);

	modport buff (input buf_wr, buf_wdata, buf_ptr, output buf_rdata);

endinterface

interface mount_iface import disk_pkg::*; ();

	logic             mounted;
	logic [DRV_W-1:0] fileno;
	logic [1:0]       img_type;
	logic             read_only;
	logic [LBA_W-1:0] file_size;

	modport src (output mounted, fileno, img_type, read_only, file_size);

	modport sink (input mounted, fileno, img_type, read_only, file_size);

endinterface

// ==== design/ctrl_pkg.sv ====
// ====================
// Controller-side definitions
// Command word layout and status byte bit positions
// ====================

package ctrl_pkg;

	// Decoded view of the command word, MSB first
	typedef struct packed {
		logic [2:0] drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} cmd_fields_t;

	// Same six bits, seen raw or as fields
	typedef union packed {
		logic [5:0]  raw;
		cmd_fields_t fields;
	} cmd_word_u;

	// ====================
	// Status byte layout
	// ====================
	// Single-bit flags
	localparam int ST_IO_DONE = 0;
	localparam int ST_MOUNTED = 1;
	localparam int ST_RO      = 7;

	// Low bit of multi-bit fields
	// fileno spans 4:2, image type spans 6:5
	localparam int ST_FILENO = 2;
	localparam int ST_TYPE   = 5;

endpackage

// ==== design/ctrl_port.sv ====
// ====================
// Controller register port
// Strobe edge detection, block address latch,
// sector buffer pointer, status and read data
// ====================

`timescale 1ns/1ns

module ctrl_port import disk_pkg::*, ctrl_pkg::*; #(
	parameter int BUF_AW = BUF_AW_DEF
) (
	input  logic             clk_sys,
	input  logic             areset,
	input  cmd_word_u        ctrl_cmd_i,
	input  logic [LBA_W-1:0] ctrl_data_i,
	input  logic             ctrl_data_wr_i,
	input  logic             ctrl_data_rd_i,
	input  logic             ctrl_io_wr_i,
	input  logic             io_done_i,
	ctrl_evt_if.src          evt,
	mount_iface.sink         mnt,
	output logic [7:0]       ctrl_status_o,
	output logic [LBA_W-1:0] ctrl_rdata_o,
	output logic [LBA_W-1:0] sd_lba_o
);

	// Strobe history
	logic      wr_q1;
	logic      wr_q2;
	logic      rd_q;
	cmd_word_u cmd_q;

	logic              wr_rise;
	logic              rd_fall;
	logic              buf_wr_q;
	logic [7:0]        buf_wdata_q;
	logic [BUF_AW-1:0] buf_ptr_q;

	// ====================
	// Strobe edges
	// ====================
	// Data write strobe is acted on after two register stages
	assign wr_rise = wr_q1 & ~wr_q2;
	assign rd_fall = rd_q & ~ctrl_data_rd_i;

	// Block requests fire on the rising edge of the command bit
	assign evt.blk_rd_req = ctrl_cmd_i.fields.block_rd & ~cmd_q.fields.block_rd;
	assign evt.blk_wr_req = ctrl_cmd_i.fields.block_wr & ~cmd_q.fields.block_wr;
	assign evt.drv_num    = ctrl_cmd_i.fields.drv_num;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_q1     <= 1'b0;
			wr_q2     <= 1'b0;
			rd_q      <= 1'b0;
			cmd_q.raw <= '0;
			buf_wr_q  <= 1'b0;
			buf_ptr_q <= '0;
		end else begin
			wr_q1     <= ctrl_data_wr_i;
			wr_q2     <= wr_q1;
			rd_q      <= ctrl_data_rd_i;
			cmd_q.raw <= ctrl_cmd_i.raw;

			buf_wr_q <= 1'b0;
			if (wr_rise && !ctrl_cmd_i.fields.lba_sel)
				buf_wr_q <= 1'b1;

			// Advance after a buffer write or at the end of a read
			if (buf_wr_q)
				buf_ptr_q <= buf_ptr_q + 1'b1;
			if (rd_fall)
				buf_ptr_q <= buf_ptr_q + 1'b1;

			// io_wr rewinds the pointer and overrides any advance
			if (ctrl_io_wr_i)
				buf_ptr_q <= '0;
		end
	end

	// Block address and write byte
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			if (ctrl_cmd_i.fields.lba_sel)
				sd_lba_o <= ctrl_data_i;
			else
				buf_wdata_q <= ctrl_data_i[7:0];
		end
	end

	assign evt.buf_wr    = buf_wr_q;
	assign evt.buf_wdata = buf_wdata_q;
	assign evt.buf_ptr   = buf_ptr_q;

	// ====================
	// Status and read data
	// ====================
	always_comb begin
		ctrl_status_o                     = '0;
		ctrl_status_o[ST_IO_DONE]         = io_done_i;
		ctrl_status_o[ST_MOUNTED]         = mnt.mounted;
		ctrl_status_o[ST_FILENO +: DRV_W] = mnt.fileno;
		ctrl_status_o[ST_TYPE +: 2]       = mnt.img_type;
		ctrl_status_o[ST_RO]              = mnt.read_only;
	end

	// File size while lba_sel is set, else the byte under the pointer
	assign ctrl_rdata_o = ctrl_cmd_i.fields.lba_sel ? mnt.file_size :
		{{(LBA_W-8){1'b0}}, evt.buf_rdata};

endmodule

// ==== design/disk_bridge_top.sv ====
// ====================
// Disk bridge top level
// Controller port, sector buffer, storage
// request tracker and mount tracker
// ====================

`timescale 1ns/1ns

module disk_bridge_top import disk_pkg::*; #(
	parameter int BUF_AW = BUF_AW_DEF
) (
	input  logic                  clk_sys,
	input  logic                  areset,

	// Controller side
	input  logic [5:0]            ctrl_cmd_i,
	input  logic [LBA_W-1:0]      ctrl_data_i,
	input  logic                  ctrl_data_wr_i,
	input  logic                  ctrl_data_rd_i,
	input  logic                  ctrl_io_wr_i,
	output logic [7:0]            ctrl_status_o,
	output logic [LBA_W-1:0]      ctrl_rdata_o,

	// Host block storage
	output logic [LBA_W-1:0]      sd_lba_o,
	output logic [NUM_DRIVES-1:0] sd_rd_o,
	output logic [NUM_DRIVES-1:0] sd_wr_o,
	output logic [7:0]            sd_buff_din_o,
	input  logic [NUM_DRIVES-1:0] sd_ack_i,
	input  logic [BUF_AW-1:0]     sd_buff_addr_i,
	input  logic [7:0]            sd_buff_dout_i,
	input  logic                  sd_buff_wr_i,

	// Image mount
	input  logic [NUM_DRIVES-1:0] img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic [LBA_W-1:0]      img_size_i,
	input  logic [1:0]            img_type_i
);

	logic io_done;

	ctrl_evt_if #(.BUF_AW(BUF_AW)) evt_bus ();
	mount_iface mnt_bus ();

	ctrl_port #(.BUF_AW(BUF_AW)) i_ctrl_port (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctrl_cmd_i     (ctrl_cmd_i),
		.ctrl_data_i    (ctrl_data_i),
		.ctrl_data_wr_i (ctrl_data_wr_i),
		.ctrl_data_rd_i (ctrl_data_rd_i),
		.ctrl_io_wr_i   (ctrl_io_wr_i),
		.io_done_i      (io_done),
		.evt            (evt_bus.src),
		.mnt            (mnt_bus.sink),
		.ctrl_status_o  (ctrl_status_o),
		.ctrl_rdata_o   (ctrl_rdata_o),
		.sd_lba_o       (sd_lba_o)
	);

	sector_buffer #(.BUF_AW(BUF_AW)) i_sector_buffer (
		.clk_sys        (clk_sys),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.evt            (evt_bus.buff),
		.sd_buff_din_o  (sd_buff_din_o)
	);

	sd_request i_sd_request (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.sd_ack_i  (sd_ack_i),
		.evt       (evt_bus.req),
		.sd_rd_o   (sd_rd_o),
		.sd_wr_o   (sd_wr_o),
		.io_done_o (io_done)
	);

	mount_tracker i_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.mnt            (mnt_bus.src)
	);

endmodule

// ==== design/disk_pkg.sv ====
// ====================
// Storage-side constants for the disk bridge
// Drive count, sector buffer depth and
// block address width
// ====================

package disk_pkg;

	// Number of drives served by the host storage
	localparam int NUM_DRIVES = 8;

	// Drive number width, enough to index every drive
	localparam int DRV_W = 3;

	// Default sector buffer address width, 512 bytes
	localparam int BUF_AW_DEF = 9;

	// Block address and image size width
	localparam int LBA_W = 32;

endpackage

// ==== design/mount_tracker.sv ====
// ====================
// Image mount tracker
// Drive number, type, read-only flag, size
// and the mount toggle
// ====================

`timescale 1ns/1ns

module mount_tracker import disk_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  logic [NUM_DRIVES-1:0] img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic [LBA_W-1:0]      img_size_i,
	input  logic [1:0]            img_type_i,
	mount_iface.src               mnt
);

	logic mount_any;
	logic mount_q;
	logic mount_rise;
	logic mounted_q;

	// Highest set bit below the top drive wins,
	// the top drive only counts when it is alone
	function automatic logic [DRV_W-1:0] pick_fileno(input logic [NUM_DRIVES-1:0] mask);
		logic [DRV_W-1:0] n;
		n = '0;
		for (int i = 0; i < NUM_DRIVES - 1; i++) begin
			if (mask[i])
				n = DRV_W'(i);
		end
		if (mask == {1'b1, {(NUM_DRIVES-1){1'b0}}})
			n = DRV_W'(NUM_DRIVES - 1);
		return n;
	endfunction

	assign mount_any  = |img_mounted_i;
	assign mount_rise = mount_any & ~mount_q;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mount_q   <= 1'b0;
			mounted_q <= 1'b0;
		end else begin
			mount_q <= mount_any;
			if (mount_rise)
				mounted_q <= ~mounted_q;
		end
	end

	// Image details, captured on each mount
	always_ff @(posedge clk_sys) begin
		if (mount_rise) begin
			mnt.fileno    <= pick_fileno(img_mounted_i);
			mnt.img_type  <= img_type_i;
			// Drives 4 and 5 are always write protected
			mnt.read_only <= img_readonly_i | img_mounted_i[4] | img_mounted_i[5];
			mnt.file_size <= img_size_i;
		end
	end

	assign mnt.mounted = mounted_q;

endmodule

// ==== design/sd_request.sv ====
// ====================
// Storage request tracker
// One-hot block read and write requests per drive,
// acknowledge tracking and io_done
// ====================

`timescale 1ns/1ns

module sd_request import disk_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  logic [NUM_DRIVES-1:0] sd_ack_i,
	ctrl_evt_if.req               evt,
	output logic [NUM_DRIVES-1:0] sd_rd_o,
	output logic [NUM_DRIVES-1:0] sd_wr_o,
	output logic                  io_done_o
);

	logic [NUM_DRIVES-1:0] drv_onehot;
	logic                  ack_any;
	logic                  ack_q;

	assign ack_any = |sd_ack_i;

	// Selected drive as a one-hot mask
	always_comb begin
		drv_onehot                = '0;
		drv_onehot[evt.drv_num]   = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
			ack_q     <= 1'b0;
			io_done_o <= 1'b0;
		end else begin
			ack_q <= ack_any;

			// A new request replaces whatever was pending
			if (evt.blk_rd_req) begin
				sd_rd_o   <= drv_onehot;
				sd_wr_o   <= '0;
				io_done_o <= 1'b0;
			end else if (evt.blk_wr_req) begin
				sd_wr_o   <= drv_onehot;
				sd_rd_o   <= '0;
				io_done_o <= 1'b0;
			end

			// Host took the request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end

			// Transfer is over once the acknowledge drops
			if (ack_q && !ack_any)
				io_done_o <= 1'b1;
		end
	end

endmodule

// ==== design/sector_buffer.sv ====
// ====================
// Sector buffer
// True dual-port byte memory, host storage on
// one port and the controller on the other
// ====================

`timescale 1ns/1ns

module sector_buffer import disk_pkg::*; #(
	parameter int BUF_AW = BUF_AW_DEF
) (
	input  logic              clk_sys,
	input  logic [BUF_AW-1:0] sd_buff_addr_i,
	input  logic [7:0]        sd_buff_dout_i,
	input  logic              sd_buff_wr_i,
	ctrl_evt_if.buff          evt,
	output logic [7:0]        sd_buff_din_o
);

	localparam int DEPTH = 1 << BUF_AW;

	logic [7:0] mem [DEPTH];

	logic [7:0] host_q;
	logic [7:0] ctrl_q;

	// ====================
	// Both ports
	// ====================
	// Registered reads, one cycle of latency on each side
	always_ff @(posedge clk_sys) begin
		// Host storage port
		if (sd_buff_wr_i)
			mem[sd_buff_addr_i] <= sd_buff_dout_i;
		host_q <= mem[sd_buff_addr_i];

		// Controller port
		if (evt.buf_wr)
			mem[evt.buf_ptr] <= evt.buf_wdata;
		ctrl_q <= mem[evt.buf_ptr];
	end

	assign sd_buff_din_o = host_q;
	assign evt.buf_rdata = ctrl_q;

endmodule

// ==== sim/disk_bridge_sva.sv ====
// ====================
// Request tracker assertions
// Exclusive one-hot requests, io_done low
// while a request is pending
// ====================

`timescale 1ns/1ns

module disk_bridge_sva import disk_pkg::*; (
	input logic                  clk_sys,
	input logic                  areset,
	input logic [NUM_DRIVES-1:0] rd_req_i,
	input logic [NUM_DRIVES-1:0] wr_req_i,
	input logic                  io_done_i
);

	// Failed assertion count
	int error_count = 0;

	// A read and a write are never pending together
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!((|rd_req_i) && (|wr_req_i)))
	else begin
		error_count++;
		$error("read and write requests pending together");
	end

	// At most one drive per direction
	a_rd_onehot: assert property (@(posedge clk_sys) disable iff (areset) $onehot0(rd_req_i))
	else begin
		error_count++;
		$error("read request is not one-hot");
	end

	a_wr_onehot: assert property (@(posedge clk_sys) disable iff (areset) $onehot0(wr_req_i))
	else begin
		error_count++;
		$error("write request is not one-hot");
	end

	// io_done only after the request bits have cleared
	a_done_idle: assert property (@(posedge clk_sys) disable iff (areset)
		((|rd_req_i) || (|wr_req_i)) |-> !io_done_i)
	else begin
		error_count++;
		$error("io_done high while a request is pending");
	end

endmodule

bind sd_request disk_bridge_sva i_sva (
	.clk_sys   (clk_sys),
	.areset    (areset),
	.rd_req_i  (sd_rd_o),
	.wr_req_i  (sd_wr_o),
	.io_done_i (io_done_o)
);

// ==== sim/tb_disk_bridge.sv ====
// ====================
// Disk bridge testbench
// Clock, reset, stimulus, reference model,
// compare process and timeout
// ====================

`timescale 1ns/1ns

module tb_disk_bridge import disk_pkg::*; ();

	localparam int DEPTH   = 1 << BUF_AW_DEF;
	localparam int N_MOUNT = 24;
	localparam int K_BYTE  = 0;
	localparam int K_WORD  = 1;
	localparam int K_MASK  = 2;

	// Rough cycle cost of each test
	localparam int LEN_RESET = 20;
	localparam int LEN_CTRL  = 4 + DEPTH * 8;
	localparam int LEN_HOST  = 4 + DEPTH * 4;
	localparam int LEN_REQ   = 2 * 40;
	localparam int LEN_MOUNT = N_MOUNT * 6;
	localparam int CYCLE_LIMIT = 2 * (LEN_RESET + LEN_CTRL + LEN_HOST + LEN_REQ + LEN_MOUNT);

	logic                  clk_sys = 1'b0;
	logic                  areset;
	logic [5:0]            ctrl_cmd_i;
	logic [LBA_W-1:0]      ctrl_data_i;
	logic                  ctrl_data_wr_i;
	logic                  ctrl_data_rd_i;
	logic                  ctrl_io_wr_i;
	logic [7:0]            ctrl_status_o;
	logic [LBA_W-1:0]      ctrl_rdata_o;
	logic [LBA_W-1:0]      sd_lba_o;
	logic [NUM_DRIVES-1:0] sd_rd_o;
	logic [NUM_DRIVES-1:0] sd_wr_o;
	logic [NUM_DRIVES-1:0] sd_ack_i;
	logic [7:0]            sd_buff_din_o;
	logic [7:0]            sd_buff_dout_i;
	logic [BUF_AW_DEF-1:0] sd_buff_addr_i;
	logic                  sd_buff_wr_i;
	logic [NUM_DRIVES-1:0] img_mounted_i;
	logic                  img_readonly_i;
	logic [LBA_W-1:0]      img_size_i;
	logic [1:0]            img_type_i;

	logic [31:0]      rng = 32'd4985;
	logic [7:0]       buf_model [DEPTH];
	string            name_q [$];
	int               kind_q [$];
	logic [LBA_W-1:0] exp_q [$];
	logic [LBA_W-1:0] act_q [$];
	event             result_ev;
	int               posted = 0;
	int               compared = 0;
	int               cycle_cnt = 0;
	logic             exp_mounted = 1'b0;

	disk_bridge_top #(.BUF_AW(BUF_AW_DEF)) i_dut (.*);

	always #5 clk_sys = ~clk_sys;

	// ====================
	// Reference model
	// ====================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Drive 7 counts only when it is the sole mounted drive
	function automatic logic [DRV_W-1:0] drive_fileno(input logic [NUM_DRIVES-1:0] mask);
		if (mask == 8'h80)
			return 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (mask[i])
				return DRV_W'(i);
		end
		return '0;
	endfunction

	function automatic logic write_protect(input logic [NUM_DRIVES-1:0] mask, input logic ro);
		return ro | mask[4] | mask[5];
	endfunction

	function automatic logic [7:0] status_byte(input logic done, input logic mounted,
		input logic [NUM_DRIVES-1:0] mask, input logic [1:0] typ, input logic ro);
		return {write_protect(mask, ro), typ, drive_fileno(mask), mounted, done};
	endfunction

	function automatic logic [7:0] buf_byte(input int addr);
		return buf_model[addr % DEPTH];
	endfunction

	// ====================
	// Checks
	// ====================
	task automatic report_fail(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			report_fail($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input logic [LBA_W-1:0] exp,
		input logic [LBA_W-1:0] act);
		if (act !== exp)
			report_fail($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_mask(input string name, input logic [NUM_DRIVES-1:0] exp,
		input logic [NUM_DRIVES-1:0] act);
		if (act !== exp)
			report_fail($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic post_result(input string name, input int kind,
		input logic [LBA_W-1:0] exp, input logic [LBA_W-1:0] act);
		name_q.push_back(name);
		kind_q.push_back(kind);
		exp_q.push_back(exp);
		act_q.push_back(act);
		posted++;
		-> result_ev;
	endtask

	// Compare process drains every result posted by the stimulus
	initial begin
		string            n;
		int               k;
		logic [LBA_W-1:0] e;
		logic [LBA_W-1:0] a;
		forever begin
			@(result_ev);
			while (kind_q.size() > 0) begin
				n = name_q.pop_front();
				k = kind_q.pop_front();
				e = exp_q.pop_front();
				a = act_q.pop_front();
				if (k == K_BYTE)
					check_byte(n, e[7:0], a[7:0]);
				else if (k == K_WORD)
					check_word(n, e, a);
				else
					check_mask(n, e[NUM_DRIVES-1:0], a[NUM_DRIVES-1:0]);
				compared++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT)
			report_fail($sformatf("Timeout, run exceeded %0d cycles", CYCLE_LIMIT));
		else if (i_dut.i_sd_request.i_sva.error_count != 0)
			report_fail("Request tracker assertions failed");
	end

	// ====================
	// Stimulus
	// ====================
	// Tasks start and end on a falling edge
	task automatic ctrl_write(input logic [LBA_W-1:0] data);
		ctrl_data_i    = data;
		ctrl_data_wr_i = 1'b1;
		repeat (3) @(negedge clk_sys);
		ctrl_data_wr_i = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic rewind_pointer();
		ctrl_io_wr_i = 1'b1;
		@(negedge clk_sys);
		ctrl_io_wr_i = 1'b0;
	endtask

	initial begin
		logic [LBA_W-1:0]      lba;
		logic [DRV_W-1:0]      drv;
		logic [NUM_DRIVES-1:0] onehot;
		logic [NUM_DRIVES-1:0] mask;

		areset         = 1'b1;
		ctrl_cmd_i     = '0;
		ctrl_data_i    = '0;
		ctrl_data_wr_i = 1'b0;
		ctrl_data_rd_i = 1'b0;
		ctrl_io_wr_i   = 1'b0;
		sd_ack_i       = '0;
		sd_buff_dout_i = '0;
		sd_buff_addr_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		img_type_i     = '0;
		repeat (16) @(negedge clk_sys);
		areset = 1'b0;
		@(negedge clk_sys);

		post_result("reset read request", K_MASK, '0, sd_rd_o);
		post_result("reset write request", K_MASK, '0, sd_wr_o);
		post_result("reset status", K_BYTE, 8'h00, ctrl_status_o & 8'h03);

		// Controller fills the buffer, host reads it back
		rewind_pointer();
		for (int i = 0; i < DEPTH; i++) begin
			rng = xorshift32(rng);
			buf_model[i] = rng[7:0];
			ctrl_write(rng);
		end
		for (int i = 0; i < DEPTH; i++) begin
			sd_buff_addr_i = BUF_AW_DEF'(i);
			@(negedge clk_sys);
			post_result("host read", K_BYTE, buf_byte(i), sd_buff_din_o);
		end

		// Host fills the buffer, controller reads it back
		for (int i = 0; i < DEPTH; i++) begin
			rng = xorshift32(rng);
			buf_model[i]   = rng[7:0];
			sd_buff_addr_i = BUF_AW_DEF'(i);
			sd_buff_dout_i = rng[7:0];
			sd_buff_wr_i   = 1'b1;
			@(negedge clk_sys);
		end
		sd_buff_wr_i = 1'b0;

		// Move the pointer off zero so the rewind has work to do
		ctrl_data_rd_i = 1'b1;
		@(negedge clk_sys);
		ctrl_data_rd_i = 1'b0;
		@(negedge clk_sys);
		rewind_pointer();
		for (int i = 0; i < DEPTH; i++) begin
			ctrl_data_rd_i = 1'b1;
			@(negedge clk_sys);
			post_result("controller read", K_WORD, {24'h0, buf_byte(i)}, ctrl_rdata_o);
			ctrl_data_rd_i = 1'b0;
			@(negedge clk_sys);
		end

		// Block read, then block write
		for (int n = 0; n < 2; n++) begin
			rng = xorshift32(rng);
			lba    = rng;
			drv    = rng[DRV_W-1:0];
			onehot = NUM_DRIVES'(1) << drv;
			ctrl_cmd_i = 6'b000001;
			ctrl_write(lba);
			post_result("lba latch", K_WORD, lba, sd_lba_o);
			ctrl_cmd_i = {drv, n == 1, n == 0, 1'b0};
			@(negedge clk_sys);
			post_result("block request", K_MASK, onehot, (n == 1) ? sd_wr_o : sd_rd_o);
			post_result("io_done cleared", K_BYTE, 8'h00, ctrl_status_o & 8'h01);
			sd_ack_i = onehot;
			@(negedge clk_sys);
			post_result("request cleared", K_MASK, '0, sd_rd_o | sd_wr_o);
			repeat (rng[9:8]) @(negedge clk_sys);
			sd_ack_i = '0;
			@(negedge clk_sys);
			post_result("io_done set", K_BYTE, 8'h01, ctrl_status_o & 8'h01);
			ctrl_cmd_i = '0;
			@(negedge clk_sys);
		end

		// Random mounts, io_done stays set from the last request
		ctrl_cmd_i = 6'b000001;
		for (int i = 0; i < N_MOUNT; i++) begin
			rng = xorshift32(rng);
			mask = (i % 8 == 3) ? 8'h80 : rng[7:0];
			if (mask == '0)
				mask = 8'h01;
			img_readonly_i = rng[8];
			img_type_i     = rng[10:9];
			rng = xorshift32(rng);
			img_size_i    = rng;
			img_mounted_i = mask;
			exp_mounted   = ~exp_mounted;
			@(negedge clk_sys);
			post_result("mount status", K_BYTE,
				status_byte(1'b1, exp_mounted, mask, img_type_i, img_readonly_i), ctrl_status_o);
			post_result("file size", K_WORD, img_size_i, ctrl_rdata_o);
			img_mounted_i = '0;
			@(negedge clk_sys);
		end

		@(negedge clk_sys);
		if (compared != posted)
			report_fail($sformatf("Only %0d of %0d results were compared", compared, posted));
		else if (i_dut.i_sd_request.i_sva.error_count != 0)
			report_fail("Request tracker assertions failed");
		else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
design/disk_pkg.sv
design/ctrl_pkg.sv
design/bridge_ifs.sv
design/ctrl_port.sv
design/sector_buffer.sv
design/sd_request.sv
design/mount_tracker.sv
design/disk_bridge_top.sv
sim/disk_bridge_sva.sv
sim/tb_disk_bridge.sv
